//--- src/cpuPkg.sv
`default_nettype none

package cpuPkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] addr_t;

  // Z80 register field encoding
  typedef enum logic [2:0] {
    REG_B   = 3'd0,
    REG_C   = 3'd1,
    REG_D   = 3'd2,
    REG_E   = 3'd3,
    REG_H   = 3'd4,
    REG_L   = 3'd5,
    REG_MEM = 3'd6,   // (HL)
    REG_A   = 3'd7
  } regCode_t;

  typedef enum logic {
    SEL_PC = 1'b0,
    SEL_HL = 1'b1
  } addrSel_t;

  typedef struct packed {
    addr_t addr;
    byte_t wrData;
    logic  we;
    logic  rd;
  } memBus_t;

  // Bit 0 is the highest priority source
  typedef struct packed {
    logic joypad;
    logic timer;
    logic lcdStat;
    logic vblank;
  } intReq_t;

  localparam addr_t VEC_VBLANK = 16'h0040;
  localparam addr_t VEC_LCD    = 16'h0048;
  localparam addr_t VEC_TIMER  = 16'h0050;
  localparam addr_t VEC_JOYPAD = 16'h0060;

  localparam byte_t A_RESET  = 8'h11;
  localparam addr_t PC_RESET = 16'h0000;

endpackage

`default_nettype wire

//--- src/ucodePkg.sv
`default_nettype none

package ucodePkg;

  typedef enum logic [3:0] {
    CMD_NOP  = 4'd0,
    CMD_SMA  = 4'd1,  // Set memory address select
    CMD_SRM  = 4'd2,  // Read data into register
    CMD_SMW  = 4'd3,  // Write source register to memory
    CMD_OP1  = 4'd4,  // LD r,r' or logic op, decoded from opcode
    CMD_SETI = 4'd5,
    CMD_CETI = 4'd6,
    CMD_JINT = 4'd7
  } uCmd_t;

  typedef struct packed {
    logic       incPc;
    logic       eof;
    uCmd_t      cmd;
    logic [2:0] operand;
  } uop_t;

  typedef logic [5:0] uPc_t;

  // Operand values for SMA
  localparam logic [2:0] OPD_PC = {2'b00, cpuPkg::SEL_PC};
  localparam logic [2:0] OPD_HL = {2'b00, cpuPkg::SEL_HL};

  // ---------------------------------------------------------------------
  // Flow entry points in the micro-op ROM
  localparam uPc_t FLOW_NOP  = 6'd0;
  localparam uPc_t FLOW_LDRN = 6'd1;
  localparam uPc_t FLOW_LDRR = 6'd4;
  localparam uPc_t FLOW_STHL = 6'd6;
  localparam uPc_t FLOW_EI   = 6'd9;
  localparam uPc_t FLOW_DI   = 6'd11;
  localparam uPc_t FLOW_INT  = 6'd13;

  typedef struct packed {
    logic          valid;
    uop_t          uop;
    cpuPkg::byte_t opcode;
  } uopIssue_t;

  typedef struct packed {
    logic             regWe;
    cpuPkg::regCode_t regDst;
    cpuPkg::byte_t    regData;
    logic             pcInc;
    logic             pcLoad;
    cpuPkg::addr_t    pcValue;
    logic             addrSelWe;
    cpuPkg::addrSel_t addrSel;
    logic             memWe;
    cpuPkg::byte_t    memWrData;
    logic             intEnWe;
    logic             intEnVal;
    logic             intAck;
  } cpuCtl_t;

  typedef struct packed {
    cpuPkg::byte_t b;
    cpuPkg::byte_t c;
    cpuPkg::byte_t d;
    cpuPkg::byte_t e;
    cpuPkg::byte_t h;
    cpuPkg::byte_t l;
    cpuPkg::byte_t a;
  } regView_t;

endpackage

`default_nettype wire

//--- src/ucodeRom.sv
`timescale 1ns/1ns
`default_nettype none

module ucodeRom
(
  input  wire ucodePkg::uPc_t uPc,
  output ucodePkg::uop_t      uop,
  input  wire logic [7:0]     opcode,
  output ucodePkg::uPc_t      flowEntry
);
  import ucodePkg::*;

  // Fields: incPc, eof, cmd, operand
  always_comb
  begin
    case (uPc)
      6'd0:    uop = '{1'b1, 1'b1, CMD_SMA, OPD_PC};   // NOP
      6'd1:    uop = '{1'b1, 1'b0, CMD_NOP, 3'd0};     // LD r,n
      6'd2:    uop = '{1'b1, 1'b0, CMD_SRM, 3'd0};
      6'd3:    uop = '{1'b0, 1'b1, CMD_SMA, OPD_PC};
      6'd4:    uop = '{1'b1, 1'b0, CMD_OP1, 3'd0};     // LD r,r' and ALU
      6'd5:    uop = '{1'b0, 1'b1, CMD_SMA, OPD_PC};
      6'd6:    uop = '{1'b1, 1'b0, CMD_SMA, OPD_HL};   // LD (HL),r
      6'd7:    uop = '{1'b0, 1'b0, CMD_SMW, 3'd0};
      6'd8:    uop = '{1'b0, 1'b1, CMD_SMA, OPD_PC};
      6'd9:    uop = '{1'b1, 1'b0, CMD_SETI, 3'd0};    // EI
      6'd10:   uop = '{1'b0, 1'b1, CMD_SMA, OPD_PC};
      6'd11:   uop = '{1'b1, 1'b0, CMD_CETI, 3'd0};    // DI
      6'd12:   uop = '{1'b0, 1'b1, CMD_SMA, OPD_PC};
      6'd13:   uop = '{1'b0, 1'b0, CMD_JINT, 3'd0};    // Interrupt entry
      6'd14:   uop = '{1'b0, 1'b1, CMD_SMA, OPD_PC};
      default: uop = '{1'b0, 1'b1, CMD_SMA, OPD_PC};
    endcase
  end

  //----------------------------------------------------------------------
  // Opcode lookup, register code 6 means (HL) and is not decoded here
  always_comb
  begin
    casez (opcode)
      8'b00110110: flowEntry = FLOW_NOP;               // LD (HL),n
      8'b00???110: flowEntry = FLOW_LDRN;
      8'b01110110: flowEntry = FLOW_NOP;               // HALT
      8'b01110???: flowEntry = FLOW_STHL;
      8'b01???110: flowEntry = FLOW_NOP;               // LD r,(HL)
      8'b01??????: flowEntry = FLOW_LDRR;
      8'b10100???,
      8'b10101???,
      8'b10110???:
      begin
        flowEntry = (opcode[2:0] == 3'b110) ? FLOW_NOP : FLOW_LDRR;
      end
      8'hfb:       flowEntry = FLOW_EI;
      8'hf3:       flowEntry = FLOW_DI;
      default:     flowEntry = FLOW_NOP;
    endcase
  end

endmodule

`default_nettype wire

//--- src/microSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module microSequencer
(
  input  wire                  iClock,
  input  wire                  arstN,
  input  wire cpuPkg::byte_t   rdData,
  input  wire                  intTake,
  output ucodePkg::uopIssue_t  issue,
  output logic                 busRead
);
  import cpuPkg::*;
  import ucodePkg::*;

  typedef enum logic [1:0] {
    AFTER_RESET,
    START_FLOW,
    RUN_FLOW,
    END_FLOW
  } seqState_t;

  seqState_t state;
  uPc_t      uPc;
  uPc_t      flowEntry;
  uop_t      uop;
  byte_t     opcodeReg;

  ucodeRom uRom
  (
    .uPc      (uPc),
    .uop      (uop),
    .opcode   (rdData),
    .flowEntry(flowEntry)
  );

  //----------------------------------------------------------------------
  // Flow state machine and micro PC
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      state <= AFTER_RESET;
      uPc   <= FLOW_NOP;
    end
    else
    begin
      case (state)
        AFTER_RESET: state <= START_FLOW;
        START_FLOW:
        begin
          uPc   <= intTake ? FLOW_INT : flowEntry;  // Interrupt wins over fetch
          state <= RUN_FLOW;
        end
        RUN_FLOW:
        begin
          uPc <= uPc + 6'd1;
          if (uop.eof)
            state <= END_FLOW;
        end
        END_FLOW:    state <= START_FLOW;
        default:     state <= AFTER_RESET;
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (state == START_FLOW)
      opcodeReg <= rdData;
  end

  assign issue   = '{valid: (state == RUN_FLOW), uop: uop, opcode: opcodeReg};
  assign busRead = (state == START_FLOW);

endmodule

`default_nettype wire

//--- src/interruptController.sv
`timescale 1ns/1ns
`default_nettype none

module interruptController
(
  input  wire                    iClock,
  input  wire                    arstN,
  input  wire cpuPkg::intReq_t   intReq,
  input  wire ucodePkg::cpuCtl_t ctl,
  output logic                   intTake,
  output cpuPkg::addr_t          vector
);
  import cpuPkg::*;

  intReq_t pending;
  logic    intEn;

  // Sticky latch, new requests still land in the ack cycle
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      pending <= '0;
      intEn   <= 1'b0;
    end
    else
    begin
      pending <= (ctl.intAck ? 4'b0000 : pending) | intReq;
      if (ctl.intAck)
        intEn <= 1'b0;
      else if (ctl.intEnWe)
        intEn <= ctl.intEnVal;
    end
  end

  assign intTake = (pending != '0) && intEn;

  // Lowest pending bit selects the vector
  always_comb
  begin
    if (pending.vblank)
      vector = VEC_VBLANK;
    else if (pending.lcdStat)
      vector = VEC_LCD;
    else if (pending.timer)
      vector = VEC_TIMER;
    else
      vector = VEC_JOYPAD;
  end

endmodule

`default_nettype wire

//--- src/cpuRegisters.sv
`timescale 1ns/1ns
`default_nettype none

module cpuRegisters
(
  input  wire                    iClock,
  input  wire                    arstN,
  input  wire ucodePkg::cpuCtl_t ctl,
  input  wire                    busRead,
  output ucodePkg::regView_t     view,
  output cpuPkg::memBus_t        bus
);
  import cpuPkg::*;

  byte_t    b, c, d, e, h, l, a;
  addr_t    pc;
  addrSel_t addrSel;

  //----------------------------------------------------------------------
  // Register bank
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      b <= '0;
      c <= '0;
      d <= '0;
      e <= '0;
      h <= '0;
      l <= '0;
      a <= A_RESET;
    end
    else if (ctl.regWe)
    begin
      case (ctl.regDst)
        REG_B:   b <= ctl.regData;
        REG_C:   c <= ctl.regData;
        REG_D:   d <= ctl.regData;
        REG_E:   e <= ctl.regData;
        REG_H:   h <= ctl.regData;
        REG_L:   l <= ctl.regData;
        REG_A:   a <= ctl.regData;
        default: ;  // (HL) is never a register target
      endcase
    end
  end

  // PC and address select
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      pc      <= PC_RESET;
      addrSel <= SEL_PC;
    end
    else
    begin
      if (ctl.pcLoad)
        pc <= ctl.pcValue;
      else if (ctl.pcInc)
        pc <= pc + 16'd1;
      if (ctl.addrSelWe)
        addrSel <= ctl.addrSel;
    end
  end

  assign view = '{b: b, c: c, d: d, e: e, h: h, l: l, a: a};

  assign bus.addr   = (addrSel == SEL_HL) ? {h, l} : pc;
  assign bus.wrData = ctl.memWrData;
  assign bus.we     = ctl.memWe;
  assign bus.rd     = busRead;

endmodule

`default_nettype wire

//--- src/uopExecute.sv
`timescale 1ns/1ns
`default_nettype none

module uopExecute
(
  input  wire ucodePkg::uopIssue_t issue,
  input  wire ucodePkg::regView_t  view,
  input  wire cpuPkg::byte_t       rdData,
  input  wire cpuPkg::addr_t       vector,
  output ucodePkg::cpuCtl_t        ctl,
  output logic                     srmRead
);
  import cpuPkg::*;
  import ucodePkg::*;

  byte_t srcData;
  byte_t aluOut;
  logic  valid;

  assign valid = issue.valid;

  // Source register from opcode bits 2..0
  always_comb
  begin
    case (regCode_t'(issue.opcode[2:0]))
      REG_B:   srcData = view.b;
      REG_C:   srcData = view.c;
      REG_D:   srcData = view.d;
      REG_E:   srcData = view.e;
      REG_H:   srcData = view.h;
      REG_L:   srcData = view.l;
      REG_A:   srcData = view.a;
      default: srcData = '0;
    endcase
  end

  always_comb
  begin
    case (issue.opcode[4:3])
      2'b00:   aluOut = view.a & srcData;   // 0xA0 group
      2'b01:   aluOut = view.a ^ srcData;   // 0xA8 group
      2'b10:   aluOut = view.a | srcData;   // 0xB0 group
      default: aluOut = view.a;
    endcase
  end

  //----------------------------------------------------------------------
  // Command decode, every enable qualified by valid
  always_comb
  begin
    ctl         = '0;
    srmRead     = 1'b0;
    ctl.pcInc   = valid & issue.uop.incPc;
    ctl.pcValue = vector;
    case (issue.uop.cmd)
      CMD_SMA:
      begin
        ctl.addrSelWe = valid;
        ctl.addrSel   = addrSel_t'(issue.uop.operand[0]);
      end
      CMD_SRM:
      begin
        ctl.regWe   = valid;
        ctl.regDst  = regCode_t'(issue.opcode[5:3]);
        ctl.regData = rdData;
        srmRead     = valid;
      end
      CMD_SMW:
      begin
        ctl.memWe     = valid;
        ctl.memWrData = srcData;
      end
      CMD_OP1:
      begin
        ctl.regWe = valid;
        if (issue.opcode[7:6] == 2'b01)
        begin
          ctl.regDst  = regCode_t'(issue.opcode[5:3]);
          ctl.regData = srcData;
        end
        else
        begin
          ctl.regDst  = REG_A;
          ctl.regData = aluOut;
        end
      end
      CMD_SETI:
      begin
        ctl.intEnWe  = valid;
        ctl.intEnVal = 1'b1;
      end
      CMD_CETI: ctl.intEnWe = valid;
      CMD_JINT:
      begin
        ctl.pcLoad = valid;
        ctl.intAck = valid;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/cpuTop.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTop
(
  input  wire                  iClock,
  input  wire                  arstN,
  input  wire cpuPkg::byte_t   rdData,
  input  wire cpuPkg::intReq_t intReq,
  output cpuPkg::memBus_t      bus
);
  import cpuPkg::*;
  import ucodePkg::*;

  uopIssue_t issue;
  cpuCtl_t   ctl;
  regView_t  view;
  addr_t     vector;
  logic      intTake;
  logic      fetchRead;
  logic      srmRead;
  logic      busRead;

  assign busRead = fetchRead | srmRead;  // Opcode fetch or SRM operand read

  microSequencer uSeq
  (
    .iClock (iClock),
    .arstN  (arstN),
    .rdData (rdData),
    .intTake(intTake),
    .issue  (issue),
    .busRead(fetchRead)
  );

  interruptController uIntc
  (
    .iClock (iClock),
    .arstN  (arstN),
    .intReq (intReq),
    .ctl    (ctl),
    .intTake(intTake),
    .vector (vector)
  );

  cpuRegisters uRegs
  (
    .iClock (iClock),
    .arstN  (arstN),
    .ctl    (ctl),
    .busRead(busRead),
    .view   (view),
    .bus    (bus)
  );

  uopExecute uExec
  (
    .issue  (issue),
    .view   (view),
    .rdData (rdData),
    .vector (vector),
    .ctl    (ctl),
    .srmRead(srmRead)
  );

endmodule

`default_nettype wire

//--- sim/cpuTbChecks.svh
`ifndef CPU_TB_CHECKS_SVH
`define CPU_TB_CHECKS_SVH

// ----------------------------------------------------------------------
// Compare tasks, one per result type
task automatic checkByte(input byte_t got, input byte_t exp, input string what);
  if (got !== exp)
  begin
    $display("ERR @%0t: %s got %02h expected %02h", $time, what, got, exp);
    $display("RESULT: FAIL");
    $fatal(1, "data mismatch");
  end
endtask

task automatic checkAddr(input addr_t got, input addr_t exp, input string what);
  if (got !== exp)
  begin
    $display("ERR @%0t: %s got %04h expected %04h", $time, what, got, exp);
    $display("RESULT: FAIL");
    $fatal(1, "address mismatch");
  end
endtask

`endif

//--- sim/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb;
  import cpuPkg::*;

  localparam int TIMEOUT_CYCLES = 6000;  // About four times the program length

  logic    iClock;
  logic    arstN;
  byte_t   rdData;
  intReq_t intReq;
  memBus_t bus;

  byte_t       mem [0:65535];
  addr_t       logAddr[$];
  byte_t       logData[$];
  addr_t       expAddr[$];
  byte_t       expData[$];
  byte_t       model [0:7];    // Expected register contents by code
  addr_t       progPtr;
  logic [31:0] lfsrState = 32'hc0ba;
  int          cycleCount = 0;

  `include "cpuTbChecks.svh"

  cpuTop dut0
  (
    .iClock(iClock),
    .arstN (arstN),
    .rdData(rdData),
    .intReq(intReq),
    .bus   (bus)
  );

  initial
  begin
    iClock = 1'b0;
    forever #10 iClock = ~iClock;
  end

  assign rdData = bus.rd ? mem[bus.addr] : 'x;  // Data only while bus.rd is high

  always @(posedge iClock)
  begin
    if (bus.we === 1'b1)
    begin
      mem[bus.addr] <= bus.wrData;
      logAddr.push_back(bus.addr);
      logData.push_back(bus.wrData);
    end
  end

  always @(posedge iClock)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the CPU stopped writing before all expected writes appeared");
      $display("RESULT: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ----------------------------------------------------------------------
  // Random source and program building
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    lfsrNext = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int n, output logic [7:0] v);
    v = '0;
    repeat (n)
    begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[6:0], lfsrState[0]};
    end
  endtask

  // Code 6 is (HL) so it folds onto A
  function automatic regCode_t pickCode(input logic [2:0] bits);
    pickCode = (bits == 3'd6) ? REG_A : regCode_t'(bits);
  endfunction

  task automatic emit(input byte_t value);
    mem[progPtr] = value;
    progPtr = progPtr + 16'd1;
  endtask

  task automatic emitLdRn(input regCode_t dst, input byte_t value);
    emit({2'b00, dst, 3'b110});
    emit(value);
    model[dst] = value;
  endtask

  task automatic emitLdRr(input regCode_t dst, input regCode_t src);
    emit({2'b01, dst, src});
    model[dst] = model[src];
  endtask

  task automatic emitAlu(input logic [1:0] op, input regCode_t src);
    emit({3'b101, op, src});
    case (op)
      2'd0:    model[REG_A] = model[REG_A] & model[src];
      2'd1:    model[REG_A] = model[REG_A] ^ model[src];
      default: model[REG_A] = model[REG_A] | model[src];
    endcase
  endtask

  task automatic emitStore(input regCode_t src);
    emit({2'b01, 3'b110, src});
    expAddr.push_back({model[REG_H], model[REG_L]});
    expData.push_back(model[src]);
  endtask

  // H keeps bit 7 set so stores never land on the program
  task automatic loadRandom(input regCode_t dst);
    logic [7:0] v;
    drawBits(8, v);
    if (dst == REG_H)
      v = v | 8'h80;
    emitLdRn(dst, v);
  endtask

  // ----------------------------------------------------------------------
  // Run control
  task automatic startProgram();
    @(negedge iClock);
    arstN  = 1'b0;
    intReq = '0;
    for (int i = 0; i < 65536; i++)
      mem[i] = 8'h00;
    logAddr.delete();
    logData.delete();
    expAddr.delete();
    expData.delete();
    for (int i = 0; i < 8; i++)
      model[i] = 8'h00;
    model[REG_A] = 8'h11;
    progPtr = 16'h0000;
  endtask

  task automatic releaseReset();
    repeat (16) @(negedge iClock);
    checkByte({6'b0, bus.we, bus.rd}, 8'h00, "bus strobes in reset");
    arstN = 1'b1;
    checkAddr(bus.addr, 16'h0000, "first fetch address");
  endtask

  task automatic waitWrites(input int n);
    while (logAddr.size() < n)
      @(negedge iClock);
  endtask

  task automatic pulseRequest(input intReq_t req);
    @(negedge iClock);
    intReq = req;
    @(negedge iClock);
    intReq = '0;
  endtask

  task automatic finishProgram(input string name);
    waitWrites(expAddr.size());
    repeat (40) @(negedge iClock);  // Any stray write shows up here
    checkByte(byte_t'(logAddr.size()), byte_t'(expAddr.size()), {name, " write count"});
    foreach (expAddr[i])
    begin
      checkAddr(logAddr[i], expAddr[i], $sformatf("%s write %0d address", name, i));
      checkByte(logData[i], expData[i], $sformatf("%s write %0d data", name, i));
    end
  endtask

  function automatic byte_t fillerOpcode(input int i);
    case (i)
      0:       fillerOpcode = 8'h00;
      1:       fillerOpcode = 8'h76;  // HALT
      2:       fillerOpcode = 8'hcb;
      3:       fillerOpcode = 8'h07;
      4:       fillerOpcode = 8'h46;  // LD B,(HL)
      5:       fillerOpcode = 8'ha6;  // AND (HL)
      6:       fillerOpcode = 8'hc3;
      default: fillerOpcode = 8'hff;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Directed tests
  task automatic testResetState();
    startProgram();
    emitLdRn(REG_H, 8'hc4);
    emitLdRn(REG_L, 8'h2e);
    emitStore(REG_A);
    releaseReset();
    finishProgram("reset state");
  endtask

  task automatic testImmediateStore();
    startProgram();
    for (int i = 0; i < 7; i++)
      loadRandom(pickCode(3'(i)));
    for (int i = 0; i < 7; i++)
      emitStore(pickCode(3'(i)));
    releaseReset();
    finishProgram("immediate");
  endtask

  task automatic testRegisterCopy();
    logic [7:0] s;
    logic [7:0] d;
    regCode_t   dst;
    startProgram();
    for (int i = 0; i < 7; i++)
      loadRandom(pickCode(3'(i)));
    repeat (12)
    begin
      drawBits(3, s);
      drawBits(3, d);
      dst = pickCode(d[2:0]);
      if (dst == REG_H)
        dst = REG_L;       // H stays high
      emitLdRr(dst, pickCode(s[2:0]));
      emitStore(dst);
    end
    releaseReset();
    finishProgram("register copy");
  endtask

  task automatic testLogic();
    logic [7:0] s;
    logic [7:0] op;
    regCode_t   src;
    startProgram();
    loadRandom(REG_H);
    loadRandom(REG_L);
    loadRandom(REG_A);
    repeat (12)
    begin
      drawBits(3, s);
      drawBits(2, op);
      src = pickCode(s[2:0]);
      loadRandom(src);
      emitAlu((op[1:0] == 2'd3) ? 2'd1 : op[1:0], src);
      emitStore(REG_A);
    end
    releaseReset();
    finishProgram("logic");
  endtask

  task automatic testInterrupts();
    startProgram();
    emit(8'hfb);                      // EI
    emit(8'hf3);                      // DI
    emitLdRn(REG_H, 8'h9a);
    emitLdRn(REG_L, 8'h35);
    emitLdRn(REG_B, 8'hb6);
    emitLdRn(REG_C, 8'h3c);
    emitLdRn(REG_D, 8'h5d);
    emitLdRn(REG_E, 8'h7e);
    emitStore(REG_B);
    repeat (4) emit(8'h00);
    emitStore(REG_C);                 // Still running under DI
    emit(8'hfb);                      // EI
    emit({2'b01, 3'b110, REG_E});     // Replaced by interrupt entry
    progPtr = 16'h0040;
    emitStore(REG_D);
    repeat (4) emit(8'h00);
    emitStore(REG_E);                 // Second request held off
    emit(8'hfb);
    emit({2'b01, 3'b110, REG_C});     // Replaced again
    progPtr = 16'h0050;
    emitStore(REG_A);
    releaseReset();
    waitWrites(1);
    pulseRequest(4'b0101);            // Vblank wins over timer
    waitWrites(3);
    pulseRequest(4'b1100);            // Timer wins over joypad
    finishProgram("interrupts");
  endtask

  task automatic testNops();
    startProgram();
    loadRandom(REG_H);
    loadRandom(REG_L);
    loadRandom(REG_B);
    loadRandom(REG_C);
    emitStore(REG_B);
    for (int i = 0; i < 8; i++)
      emit(fillerOpcode(i));
    emitStore(REG_C);
    for (int i = 7; i >= 0; i--)
      emit(fillerOpcode(i));
    emitStore(REG_B);
    releaseReset();
    finishProgram("nops");
  endtask

  initial
  begin
    arstN  = 1'b0;
    intReq = '0;
    testResetState();
    testImmediateStore();
    testRegisterCopy();
    testLogic();
    testInterrupts();
    testNops();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+sim
src/cpuPkg.sv
src/ucodePkg.sv
src/ucodeRom.sv
src/microSequencer.sv
src/interruptController.sv
src/cpuRegisters.sv
src/uopExecute.sv
src/cpuTop.sv
sim/cpuTb.sv
